/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal -j 0
TOP      = trng_tb
FILELIST = sim.f

.PHONY: simulate clean

simulate:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* common/trng_pkg.sv */
package trng_pkg;

    // Output pins are fixed at 16, so is the word
    localparam int WORD_WIDTH = 16;

    // Kind of value asked for on the request pins
    typedef enum logic [2:0] {
        REQ_WORD = 3'd0,    // Full word
        REQ_BYTE = 3'd1,    // Low byte, zero-extended
        REQ_BIT  = 3'd2,    // Single bit, zero-extended
        REQ_DICE = 3'd3     // 1 to 6
    } rand_req_t;           // Codes 4 to 7 fall back to a full word

    // One finished random word
    typedef struct packed {
        logic [WORD_WIDTH-1:0] data;
    } rand_word_t;

    // Registered request from the pins
    typedef struct packed {
        rand_req_t req_type;    // What to shape the word into
        logic      strobe;      // One cycle per request
    } rand_cmd_t;

endpackage

/* entropy/entropy_debiaser.sv */
module entropy_debiaser
    import trng_pkg::*;
#(
    parameter int ES_SOURCES = 8        // Parallel entropy inputs
) (
    input  logic                  ic_clk,
    input  logic                  reset,

    // Entropy samples
    input  logic [ES_SOURCES-1:0] es_bits,
    input  logic                  es_valid,
    output logic                  es_ready,

    // Finished words toward the FIFO
    output logic                  word_valid,
    input  logic                  word_ready,
    output rand_word_t            word
);

    localparam int CNT_W = $clog2(WORD_WIDTH);

    logic                  raw_bit;     // Fold of one sample
    logic                  sample;      // Sample taken this cycle
    logic                  have_first;  // First bit of a pair is held
    logic                  first_bit;
    logic                  yield;       // Unequal pair closes this cycle
    logic                  word_done;   // Last bit of the word yielded
    logic [WORD_WIDTH-1:0] shift_q;     // Word under assembly
    logic [CNT_W-1:0]      bit_cnt;     // Yielded bits so far

    // No sampling while a finished word waits
    assign es_ready = ~word_valid;
    assign sample   = es_valid & es_ready;

    // All sources folded into one raw bit
    assign raw_bit = ^es_bits;

    // 0 then 1 gives 0, 1 then 0 gives 1, so the yielded bit is the first one
    assign yield     = sample & have_first & (first_bit != raw_bit);
    assign word_done = yield & (bit_cnt == CNT_W'(WORD_WIDTH - 1));

    // Shift register doubles as the offered word, frozen while it waits
    assign word.data = shift_q;

    always_ff @(posedge ic_clk) begin
        if (reset) begin
            have_first <= 1'b0;
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            if (sample) begin
                have_first <= ~have_first;  // Alternate first / second of pair
            end

            if (word_done) begin
                bit_cnt <= '0;              // Start the next word
            end else if (yield) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            // Offered one cycle after the completing sample
            if (word_done) begin
                word_valid <= 1'b1;
            end else if (word_ready) begin
                word_valid <= 1'b0;         // Taken by the FIFO
            end
        end
    end

    // Pair and word payload
    always_ff @(posedge ic_clk) begin
        if (sample && !have_first) begin
            first_bit <= raw_bit;           // Hold until its partner arrives
        end
        if (yield) begin
            // Enters at the LSB, first yielded bit ends at the MSB
            shift_q <= {shift_q[WORD_WIDTH-2:0], first_bit};
        end
    end

endmodule

/* rtl/request_handler.sv */
module request_handler
    import trng_pkg::*;
(
    input  logic                  ic_clk,
    input  logic                  reset,

    // Registered request from the top
    input  rand_cmd_t             cmd,

    // Head of the word FIFO
    input  logic                  pop_valid,
    output logic                  pop_ready,
    input  rand_word_t            pop_word,

    // Answer pins
    output logic [WORD_WIDTH-1:0] rand_value,
    output logic                  rand_valid
);

    typedef enum logic [1:0] {
        IDLE,           // Ready for a request
        WAIT_WORD,      // Accepted, popping a word
        DELIVER         // Shaped value on the pins
    } state_t;

    state_t    state;
    rand_req_t req_q;   // Type of the accepted request

    // Turns a raw word into the requested kind of value
    function automatic logic [WORD_WIDTH-1:0] shape(input rand_req_t  kind,
                                                    input rand_word_t w);
        case (kind)
            REQ_BYTE: shape = {{(WORD_WIDTH - 8){1'b0}}, w.data[7:0]};
            REQ_BIT:  shape = {{(WORD_WIDTH - 1){1'b0}}, w.data[0]};
            REQ_DICE: shape = (w.data % WORD_WIDTH'(6)) + WORD_WIDTH'(1);   // 1 to 6
            default:  shape = w.data;                   // Word and unused codes
        endcase
    endfunction

    // One pop per request, only while waiting
    assign pop_ready = (state == WAIT_WORD);

    // High for the single DELIVER cycle
    assign rand_valid = (state == DELIVER);

    always_ff @(posedge ic_clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd.strobe) begin
                        state <= WAIT_WORD;
                    end
                end
                WAIT_WORD: begin
                    if (pop_valid) begin
                        state <= DELIVER;   // Stalls here on an empty FIFO
                    end
                end
                DELIVER: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request type and answer payload
    always_ff @(posedge ic_clk) begin
        if (state == IDLE && cmd.strobe) begin
            req_q <= cmd.req_type;  // Strobes outside IDLE are dropped
        end
        if (pop_valid && pop_ready) begin
            rand_value <= shape(req_q, pop_word);
        end
    end

endmodule

/* rtl/trng_top.sv */
module trng_top
    import trng_pkg::*;
#(
    parameter int ES_SOURCES = 8,   // Entropy inputs
    parameter int FIFO_DEPTH = 4    // Buffered words
) (
    input  logic                  ic_clk,
    input  logic                  reset,

    // Request pins
    input  logic                  rand_req,
    input  rand_req_t             rand_req_type,
    output logic [WORD_WIDTH-1:0] rand_value,
    output logic                  rand_valid,

    // Entropy sources
    input  logic [ES_SOURCES-1:0] es_bits,
    input  logic                  es_valid,
    output logic                  es_ready
);

    logic       reset_q;        // Reset for all blocks, one cycle late
    rand_cmd_t  cmd_q;
    logic       word_valid;
    logic       word_ready;
    rand_word_t deb_word;
    logic       pop_valid;
    logic       pop_ready;
    rand_word_t pop_word;

    always_ff @(posedge ic_clk) begin
        reset_q <= reset;
    end

    // Request pins captured once
    always_ff @(posedge ic_clk) begin
        if (reset_q) begin
            cmd_q.strobe <= 1'b0;
        end else begin
            cmd_q.strobe <= rand_req;
        end
        cmd_q.req_type <= rand_req_type;
    end

    entropy_debiaser #(
        .ES_SOURCES(ES_SOURCES)
    ) u_debiaser (
        .ic_clk    (ic_clk),
        .reset     (reset_q),
        .es_bits   (es_bits),
        .es_valid  (es_valid),
        .es_ready  (es_ready),
        .word_valid(word_valid),
        .word_ready(word_ready),
        .word      (deb_word)
    );

    word_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .ic_clk    (ic_clk),
        .reset     (reset_q),
        .push_valid(word_valid),
        .push_ready(word_ready),
        .push_word (deb_word),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready),
        .pop_word  (pop_word)
    );

    request_handler u_handler (
        .ic_clk    (ic_clk),
        .reset     (reset_q),
        .cmd       (cmd_q),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready),
        .pop_word  (pop_word),
        .rand_value(rand_value),
        .rand_valid(rand_valid)
    );

endmodule

/* rtl/word_fifo.sv */
module word_fifo
    import trng_pkg::*;
#(
    parameter int FIFO_DEPTH = 4        // Power of two
) (
    input  logic       ic_clk,
    input  logic       reset,

    // Write side from the debiaser
    input  logic       push_valid,
    output logic       push_ready,
    input  rand_word_t push_word,

    // Read side toward the handler
    output logic       pop_valid,
    input  logic       pop_ready,
    output rand_word_t pop_word
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    rand_word_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;         // Words held
    logic             do_push;
    logic             do_pop;

    assign push_ready = (fill != CNT_W'(FIFO_DEPTH));   // Low only when full
    assign pop_valid  = (fill != '0);
    assign pop_word   = mem[rd_ptr];                    // Head, no extra latency

    assign do_push = push_valid & push_ready;
    assign do_pop  = pop_valid & pop_ready;

    // Pointers and fill
    always_ff @(posedge ic_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at the power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // Push and pop together leave the fill alone
            if (do_push && !do_pop) begin
                fill <= fill + 1'b1;
            end else if (do_pop && !do_push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge ic_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

endmodule

/* sim.f */
common/trng_pkg.sv
entropy/entropy_debiaser.sv
rtl/word_fifo.sv
rtl/request_handler.sv
rtl/trng_top.sv
testbench/trng_tb.sv

/* testbench/trng_tb.sv */
module trng_tb
    import trng_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ES_SOURCES = 8;
    localparam int FIFO_DEPTH = 4;
    localparam logic [31:0] SEED = 32'h13c6_83fa;
    localparam int SRC_OFF    = 0;      // es_valid held low
    localparam int SRC_RANDOM = 1;
    localparam int SRC_CONST  = 2;      // Every raw pair equal
    localparam int TIMEOUT    = 4000;   // Cycles per wait

    logic                  ic_clk;
    logic                  reset;
    logic                  rand_req;
    rand_req_t             rand_req_type;
    logic [ES_SOURCES-1:0] es_bits = '0;
    logic                  es_valid = 1'b0;
    logic                  es_ready;
    logic [WORD_WIDTH-1:0] rand_value;
    logic                  rand_valid;

    int          src_mode = SRC_OFF;
    logic [31:0] es_seed = SEED;
    logic [31:0] req_seed = ~SEED;      // Separate stream for request types
    int          errors = 0;
    int          checks = 0;
    logic [15:0] exp_q [$];             // Model words, oldest first
    bit          pair_open = 1'b0;      // First raw bit of a pair held
    logic        first_raw;
    logic [15:0] acc;                   // Word under assembly in the model
    int          acc_bits = 0;
    int          stray;
    int          highs;
    int          lat;

    trng_top #(.ES_SOURCES(ES_SOURCES), .FIFO_DEPTH(FIFO_DEPTH)) dut (
        .ic_clk(ic_clk), .reset(reset), .rand_req(rand_req), .rand_req_type(rand_req_type),
        .rand_value(rand_value), .rand_valid(rand_valid),
        .es_bits(es_bits), .es_valid(es_valid), .es_ready(es_ready)
    );

    always #50 ic_clk = ~ic_clk;    // 100 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Shaping rule per request type
    function automatic logic [15:0] expected_value(input logic [2:0] kind, input logic [15:0] w);
        case (kind)
            REQ_BYTE: return {8'h00, w[7:0]};
            REQ_BIT:  return {15'd0, w[0]};
            REQ_DICE: return (w % 16'd6) + 16'd1;
            default:  return w;         // Unused codes too
        endcase
    endfunction

    // New entropy sample 5 ns after each edge
    always @(posedge ic_clk) begin
        #5;
        es_seed = lcg_next(es_seed);
        case (src_mode)
            SRC_RANDOM: begin
                es_valid = (es_seed[31:30] != 2'b00);   // About 3 of 4 cycles
                es_bits  = es_seed[23:16];
            end
            SRC_CONST: begin
                es_valid = 1'b1;
                es_bits  = 8'h5a;                       // Even parity
            end
            default: es_valid = 1'b0;
        endcase
    end

    // Reference debiaser on the falling edge
    always @(negedge ic_clk) begin
        if (es_valid && es_ready) begin
            if (!pair_open) begin
                first_raw = ^es_bits;
                pair_open = 1'b1;
            end else begin
                pair_open = 1'b0;
                if (first_raw != ^es_bits) begin    // 1,0 gives 1 and 0,1 gives 0
                    acc = {acc[14:0], first_raw};   // First yielded bit ends at the MSB
                    acc_bits++;
                    if (acc_bits == 16) begin
                        exp_q.push_back(acc);
                        acc_bits = 0;
                    end
                end
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("timed out waiting for %s", what);
        $display("checks %0d errors %0d", checks, errors);
        $display("TESTS FAILED");
        $finish;
    endtask

    // One-cycle request strobe
    task automatic send_strobe(input logic [2:0] kind);
        rand_req      = 1'b1;
        rand_req_type = rand_req_t'(kind);
        @(posedge ic_clk);
        #5;
        rand_req = 1'b0;
    endtask

    // Counts falling edges until rand_valid
    task automatic wait_answer(input string name, output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge ic_clk);
            cycles++;
            seen = rand_valid;
            if (!seen && cycles >= TIMEOUT) stop_on_timeout({"rand_valid in ", name});
        end
    endtask

    // Called on the falling edge that shows rand_valid
    task automatic take_answer(input string name, input logic [2:0] kind);
        logic [15:0] word;
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s was answered while the model had no word", name);
        end else begin
            word = exp_q.pop_front();
            compare(name, 32'(expected_value(kind, word)), 32'(rand_value));
            if (kind == REQ_DICE) begin
                compare({name, " dice range"}, 1, 32'(rand_value >= 1 && rand_value <= 6));
            end
        end
        @(negedge ic_clk);
        compare({name, " valid width"}, 0, 32'(rand_valid));   // One cycle only
        @(posedge ic_clk);
        #5;
    endtask

    task automatic request_value(input string name, input logic [2:0] kind, input bit twice);
        bit had_word;
        int cycles;
        had_word = (exp_q.size() != 0);
        send_strobe(kind);
        if (twice) begin
            @(posedge ic_clk);
            #5;
            send_strobe(kind);          // Dropped while the handler is busy
        end
        wait_answer(name, cycles);
        if (had_word && !twice) compare({name, " latency"}, 3, cycles);
        take_answer(name, kind);
    endtask

    // Empties the DUT of every word the model knows about
    task automatic drain_model();
        while (exp_q.size() != 0) request_value("drain", REQ_WORD, 1'b0);
    endtask

    initial begin
        ic_clk        = 1'b0;
        reset         = 1'b1;
        rand_req      = 1'b0;
        rand_req_type = REQ_WORD;
        repeat (4) @(posedge ic_clk);
        #5;
        reset = 1'b0;
        repeat (2) @(posedge ic_clk);   // Registered reset released
        @(negedge ic_clk);
        compare("reset rand_valid", 0, 32'(rand_valid));
        compare("reset es_ready", 1, 32'(es_ready));
        src_mode = SRC_RANDOM;
        @(posedge ic_clk);
        #5;

        for (int i = 0; i < 6; i++) request_value("word", REQ_WORD, 1'b0);
        for (int i = 0; i < 3; i++) begin
            request_value("byte", REQ_BYTE, 1'b0);
            request_value("bit", REQ_BIT, 1'b0);
            request_value("dice", REQ_DICE, 1'b0);
        end
        for (int i = 0; i < 12; i++) begin
            req_seed = lcg_next(req_seed);
            request_value($sformatf("random type %0d", i), req_seed[30:28], 1'b0);
        end

        // Constant source lets no word form
        @(negedge ic_clk);
        src_mode = SRC_CONST;
        repeat (10) @(posedge ic_clk);
        #5;
        drain_model();
        send_strobe(REQ_WORD);
        stray = 0;
        for (int i = 0; i < 200; i++) begin
            @(negedge ic_clk);
            if (rand_valid) stray++;
        end
        compare("stall no answer", 0, stray);
        src_mode = SRC_RANDOM;          // First new word answers the waiting request
        wait_answer("resume", lat);
        take_answer("resume", REQ_WORD);

        // Back-pressure with no requests
        drain_model();
        lat = 0;
        while (exp_q.size() < FIFO_DEPTH + 1) begin
            @(negedge ic_clk);
            lat++;
            if (lat >= TIMEOUT) stop_on_timeout("the FIFO to fill");
        end
        repeat (5) @(negedge ic_clk);
        highs = 0;
        for (int i = 0; i < 50; i++) begin
            @(negedge ic_clk);
            if (es_ready) highs++;
        end
        compare("full es_ready", 0, highs);
        compare("full word count", FIFO_DEPTH + 1, exp_q.size());
        @(posedge ic_clk);
        #5;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) request_value("held word", REQ_WORD, 1'b0);

        // Two words waiting, so the second strobe lands in DELIVER
        lat = 0;
        while (exp_q.size() < 2) begin
            @(negedge ic_clk);
            lat++;
            if (lat >= TIMEOUT) stop_on_timeout("two words before the double strobe");
        end
        @(posedge ic_clk);
        #5;

        // Second strobe while busy
        request_value("double strobe", REQ_WORD, 1'b1);
        stray = 0;
        for (int i = 0; i < 20; i++) begin
            @(negedge ic_clk);
            if (rand_valid) stray++;
        end
        compare("double strobe extra answer", 0, stray);
        @(posedge ic_clk);
        #5;
        request_value("after double", REQ_WORD, 1'b0);  // Next model word, none skipped

        repeat (5) @(posedge ic_clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
